// File: knight_pkg.sv
package knight_pkg;

  ////////////////////
  // sample path
  ////////////////////
  localparam int DUTY_W         = 11;  // pwm period is 2**DUTY_W cycles
  localparam int NUM_CH         = 4;   // capture channels on the sample bus
  localparam int SAMPLE_CREDITS = 4;   // engine sample buffer depth
  localparam int CREDIT_W       = $clog2(SAMPLE_CREDITS + 1);

  typedef logic [1:0]        ch_id_t;  // channel id on the sample bus
  typedef logic [DUTY_W-1:0] duty_t;   // high cycles per period

  // channel map
  localparam ch_id_t CH_LFT_FWD  = 2'd0;
  localparam ch_id_t CH_LFT_REV  = 2'd1;
  localparam ch_id_t CH_RGHT_FWD = 2'd2;
  localparam ch_id_t CH_RGHT_REV = 2'd3;

  ////////////////////
  // wheel dynamics
  ////////////////////
  typedef logic signed [15:0] omega_t;   // wheel angular speed
  typedef logic signed [12:0] alpha_t;   // wheel angular accel

  localparam omega_t OMEGA_MAX     = 16'sd32700;  // speed clamp, both signs
  localparam alpha_t FRICTION_BAND = 13'sd32;     // below this, friction wins

  ////////////////////
  // platform
  ////////////////////
  typedef logic signed [19:0] heading_t;  // 0 is north, full circle wraps
  typedef logic [14:0]        pos_t;      // 4096 counts per square

  localparam omega_t   MOVE_MIN      = 16'sd1000;  // both wheels above this to travel
  localparam pos_t     START_XY      = 15'h2800;   // center of square 2.5
  localparam heading_t START_HEADING = 20'sh00000;

  // center line bands, low 12 bits of a coordinate, exclusive bounds
  localparam logic [11:0] LINE_LO1 = 12'h3E0;
  localparam logic [11:0] LINE_HI1 = 12'h460;
  localparam logic [11:0] LINE_LO2 = 12'hBA0;
  localparam logic [11:0] LINE_HI2 = 12'hC20;

  // guardrail bands on the lateral coordinate
  localparam logic [11:0]        RAIL_LO    = 12'h710;
  localparam logic [11:0]        RAIL_HI    = 12'h8F0;
  localparam logic signed [16:0] RAIL_SPEED = 17'sd22000;  // omega sum threshold

  localparam pos_t BORDER_Y = 15'h5000;  // board edge, every sensor sees it

  // cardinal bands on heading[19:8]
  localparam logic [11:0] HEADING_NORTH_LO = 12'hFB8;  // north wraps through zero
  localparam logic [11:0] HEADING_NORTH_HI = 12'h048;
  localparam logic [11:0] HEADING_EAST_LO  = 12'hBB8;
  localparam logic [11:0] HEADING_EAST_HI  = 12'hC48;
  localparam logic [11:0] HEADING_SOUTH_LO = 12'h7B8;
  localparam logic [11:0] HEADING_SOUTH_HI = 12'h848;
  localparam logic [11:0] HEADING_WEST_LO  = 12'h3B8;
  localparam logic [11:0] HEADING_WEST_HI  = 12'h448;

endpackage

// File: pwm_capture.sv
`timescale 1ns/1ns

module pwm_capture (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              pwm,         // motor drive line
  input  logic              sample_gnt,  // arbiter took the held duty
  output logic              sample_req,
  output knight_pkg::duty_t duty
);
  import knight_pkg::*;

  duty_t per_cnt;   // free running, all channels in phase
  duty_t high_cnt;  // high cycles so far this period
  logic  period_end;

  assign period_end = &per_cnt;  // last cycle of the period

  ////////////////////
  // counters
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      per_cnt  <= '0;
      high_cnt <= '0;
    end else begin
      per_cnt <= per_cnt + 1'b1;
      if (period_end)
        high_cnt <= '0;               // restart for next period
      else if (pwm)
        high_cnt <= high_cnt + 1'b1;
    end
  end

  // held sample, counts the last cycle too and clamps a full-on period
  always_ff @(posedge clk) begin
    if (period_end)
      duty <= (pwm && !(&high_cnt)) ? high_cnt + 1'b1 : high_cnt;
  end

  // request rises the cycle after period end, drops on grant
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      sample_req <= 1'b0;
    else if (period_end)
      sample_req <= 1'b1;
    else if (sample_gnt)
      sample_req <= 1'b0;
  end

  // the previous duty must have left before the next one loads
  overrun_chk : assert property (@(posedge clk) disable iff (!rst_n)
    period_end |-> (!sample_req || sample_gnt));

endmodule

// File: sample_arbiter.sv
`timescale 1ns/1ns

module sample_arbiter (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [knight_pkg::NUM_CH-1:0]     sample_req,
  input  knight_pkg::duty_t                 duty_in [knight_pkg::NUM_CH],
  output logic [knight_pkg::NUM_CH-1:0]     sample_gnt,
  output logic                              smp_vld,
  output knight_pkg::ch_id_t                smp_ch,
  output knight_pkg::duty_t                 smp_duty,
  input  logic                              credit_ret   // engine freed one entry
);
  import knight_pkg::*;

  ch_id_t              last_ch;    // previous winner, search starts after it
  ch_id_t              win_ch;
  logic                win_found;
  logic                gnt;
  logic [CREDIT_W-1:0] credits;    // free entries in the engine buffer
  logic [CREDIT_W:0]   avail;      // credits left after this cycle's traffic

  ////////////////////
  // round robin pick
  ////////////////////
  always_comb begin
    win_found = 1'b0;
    win_ch    = last_ch;
    for (int i = 1; i <= NUM_CH; i++) begin
      if (!win_found && sample_req[ch_id_t'(last_ch + i)]) begin  // first requester past last
        win_found = 1'b1;
        win_ch    = ch_id_t'(last_ch + i);
      end
    end
  end

  // the send already on the bus spends one, a returning credit adds one
  assign avail = (CREDIT_W+1)'(credits) - (CREDIT_W+1)'(smp_vld)
               + (CREDIT_W+1)'(credit_ret);
  assign gnt   = win_found && (avail != '0);

  assign sample_gnt = gnt ? ({{(NUM_CH-1){1'b0}}, 1'b1} << win_ch) : '0;

  ////////////////////
  // output stage
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      smp_vld <= 1'b0;
      last_ch <= ch_id_t'(NUM_CH - 1);  // channel 0 goes first
      credits <= CREDIT_W'(SAMPLE_CREDITS);
    end else begin
      smp_vld <= gnt;                   // one cycle after the grant
      if (gnt)
        last_ch <= win_ch;
      credits <= credits - CREDIT_W'(smp_vld) + CREDIT_W'(credit_ret);
    end
  end

  always_ff @(posedge clk) begin
    if (gnt) begin
      smp_ch   <= win_ch;
      smp_duty <= duty_in[win_ch];      // capture holds it until the grant
    end
  end

  credit_max_chk : assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CREDIT_W'(SAMPLE_CREDITS));

  // a send lands only while the engine still has room
  credit_zero_chk : assert property (@(posedge clk) disable iff (!rst_n)
    smp_vld |-> (credits != '0));

endmodule

// File: wheel_dynamics.sv
`timescale 1ns/1ns

module wheel_dynamics (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                smp_vld,
  input  knight_pkg::ch_id_t  smp_ch,
  input  knight_pkg::duty_t   smp_duty,
  output logic                credit_ret,
  output logic                wheel_vld,
  output knight_pkg::omega_t  omega_lft,
  output knight_pkg::omega_t  omega_rght
);
  import knight_pkg::*;

  duty_t               duty_buf [NUM_CH];  // one entry per channel
  logic [NUM_CH-1:0]   rcvd;               // which entries hold this period
  logic                full;
  logic [CREDIT_W-1:0] ret_cnt;            // credits still to hand back
  alpha_t              alpha_lft;
  alpha_t              alpha_rght;

  ////////////////////
  // physics
  ////////////////////
  // accel = torque minus drag, torque is the plain duty difference
  function automatic alpha_t calc_alpha(duty_t fwd, duty_t rev, omega_t om);
    logic signed [13:0] torque;
    logic signed [13:0] acc;
    torque = $signed({3'b000, fwd}) - $signed({3'b000, rev});
    acc    = torque - 14'(om >>> 4) - 14'(om >>> 6);
    if (acc > 14'sd4095)
      return 13'sd4095;              // clamp to 13 bit signed
    else if (acc < -14'sd4096)
      return -13'sd4096;
    return alpha_t'(acc);
  endfunction

  function automatic omega_t calc_omega(omega_t om, alpha_t acc);
    logic signed [16:0] sum;         // one extra bit so the clamp sees overflow
    sum = 17'(om) + 17'(acc >>> 3);
    if (acc > FRICTION_BAND || acc < -FRICTION_BAND) begin
      if (sum > 17'(OMEGA_MAX))
        return OMEGA_MAX;
      else if (sum < -17'(OMEGA_MAX))
        return -OMEGA_MAX;
      return omega_t'(sum);
    end
    return om - (om >>> 6);          // friction bleeds 1/64 per update
  endfunction

  assign full       = &rcvd;
  assign alpha_lft  = calc_alpha(duty_buf[CH_LFT_FWD], duty_buf[CH_LFT_REV], omega_lft);
  assign alpha_rght = calc_alpha(duty_buf[CH_RGHT_FWD], duty_buf[CH_RGHT_REV], omega_rght);

  ////////////////////
  // sample buffer
  ////////////////////
  always_ff @(posedge clk) begin
    if (smp_vld)
      duty_buf[smp_ch] <= smp_duty;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rcvd       <= '0;
      omega_lft  <= '0;
      omega_rght <= '0;
      wheel_vld  <= 1'b0;
      ret_cnt    <= '0;
      credit_ret <= 1'b0;
    end else begin
      rcvd <= (full ? '0 : rcvd) | (smp_vld ? (NUM_CH'(1) << smp_ch) : '0);
      wheel_vld <= full;             // both wheels step together
      if (full) begin
        omega_lft  <= calc_omega(omega_lft, alpha_lft);
        omega_rght <= calc_omega(omega_rght, alpha_rght);
      end
      credit_ret <= (ret_cnt != '0); // one pulse per freed entry
      if (full)
        ret_cnt <= CREDIT_W'(NUM_CH);
      else if (ret_cnt != '0)
        ret_cnt <= ret_cnt - 1'b1;
    end
  end

  // arbiter must not send a channel twice before the period is used up
  dup_sample_chk : assert property (@(posedge clk) disable iff (!rst_n)
    smp_vld |-> !rcvd[smp_ch]);

endmodule

// File: platform_integrator.sv
`timescale 1ns/1ns

module platform_integrator (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wheel_vld,
  input  knight_pkg::omega_t   omega_lft,
  input  knight_pkg::omega_t   omega_rght,
  output logic                 phys_vld,
  output knight_pkg::heading_t heading,
  output knight_pkg::pos_t     xx,
  output knight_pkg::pos_t     yy,
  output logic                 lft_ir_n,
  output logic                 cntr_ir_n,
  output logic                 rght_ir_n
);
  import knight_pkg::*;

  logic signed [16:0] omega_sum;     // positive when rolling forward
  omega_t             rate;          // platform turn rate
  heading_t           rate_x;
  heading_t           heading_nxt;
  logic [11:0]        hband;         // coarse heading for the cardinal bands
  logic               moving;
  logic               rail_on;
  logic [3:0]         step;
  pos_t               xx_nxt, yy_nxt;
  logic               lft_nxt, cntr_nxt, rght_nxt;

  function automatic logic on_line(pos_t p);
    return (p[11:0] > LINE_LO1 && p[11:0] < LINE_HI1) ||
           (p[11:0] > LINE_LO2 && p[11:0] < LINE_HI2);
  endfunction

  ////////////////////
  // heading
  ////////////////////
  assign omega_sum = 17'(omega_lft) + 17'(omega_rght);
  assign rate      = (omega_rght >>> 1) - (omega_lft >>> 1);
  assign rate_x    = heading_t'(rate);   // sign extend before weighting
  assign heading_nxt = heading + (rate_x >>> 7) + (rate_x >>> 8)
                     - (rate_x >>> 12) - (rate_x >>> 13) - (rate_x >>> 14);
  assign hband     = heading_nxt[19:8];

  assign moving  = (omega_lft > MOVE_MIN) && (omega_rght > MOVE_MIN);
  assign rail_on = omega_sum > RAIL_SPEED;
  assign step    = omega_sum[16:13];

  ////////////////////
  // position and IR
  ////////////////////
  always_comb begin
    xx_nxt   = xx;
    yy_nxt   = yy;
    lft_nxt  = 1'b1;                   // rails dark unless travelling
    rght_nxt = 1'b1;
    if (moving) begin
      if (hband >= HEADING_NORTH_LO || hband <= HEADING_NORTH_HI) begin
        yy_nxt   = yy + pos_t'(step);
        lft_nxt  = !(rail_on && xx[11:0] < RAIL_LO);
        rght_nxt = !(rail_on && xx[11:0] > RAIL_HI);
      end else if (hband >= HEADING_EAST_LO && hband <= HEADING_EAST_HI) begin
        xx_nxt   = xx + pos_t'(step);
        lft_nxt  = !(rail_on && yy[11:0] > RAIL_HI);
        rght_nxt = !(rail_on && yy[11:0] < RAIL_LO);
      end else if (hband >= HEADING_SOUTH_LO && hband <= HEADING_SOUTH_HI) begin
        yy_nxt   = yy - pos_t'(step);
        lft_nxt  = !(rail_on && xx[11:0] > RAIL_HI);
        rght_nxt = !(rail_on && xx[11:0] < RAIL_LO);
      end else if (hband >= HEADING_WEST_LO && hband <= HEADING_WEST_HI) begin
        xx_nxt   = xx - pos_t'(step);
        lft_nxt  = !(rail_on && yy[11:0] < RAIL_LO);
        rght_nxt = !(rail_on && yy[11:0] > RAIL_HI);
      end                              // off axis, no travel
    end
    cntr_nxt = !(on_line(xx_nxt) || on_line(yy_nxt));
    if (yy_nxt > BORDER_Y) begin       // board edge lights everything
      lft_nxt  = 1'b0;
      cntr_nxt = 1'b0;
      rght_nxt = 1'b0;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      phys_vld  <= 1'b0;
      heading   <= START_HEADING;
      xx        <= START_XY;
      yy        <= START_XY;
      lft_ir_n  <= 1'b1;
      cntr_ir_n <= 1'b1;
      rght_ir_n <= 1'b1;
    end else begin
      phys_vld <= wheel_vld;
      if (wheel_vld) begin
        heading   <= heading_nxt;
        xx        <= xx_nxt;
        yy        <= yy_nxt;
        lft_ir_n  <= lft_nxt;
        cntr_ir_n <= cntr_nxt;
        rght_ir_n <= rght_nxt;
      end
    end
  end

endmodule

// File: knight_physics_top.sv
`timescale 1ns/1ns

module knight_physics_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 lft_pwm1,    // left forward drive
  input  logic                 lft_pwm2,    // left reverse drive
  input  logic                 rght_pwm1,   // right forward drive
  input  logic                 rght_pwm2,   // right reverse drive
  output logic                 phys_vld,
  output knight_pkg::omega_t   omega_lft,
  output knight_pkg::omega_t   omega_rght,
  output knight_pkg::heading_t heading,
  output knight_pkg::pos_t     xx,
  output knight_pkg::pos_t     yy,
  output logic                 lft_ir_n,
  output logic                 cntr_ir_n,
  output logic                 rght_ir_n
);
  import knight_pkg::*;

  logic [NUM_CH-1:0] pwm_line;     // indexed by channel id
  logic [NUM_CH-1:0] sample_req;
  logic [NUM_CH-1:0] sample_gnt;
  duty_t             duty [NUM_CH];
  logic              smp_vld;
  ch_id_t            smp_ch;
  duty_t             smp_duty;
  logic              credit_ret;
  logic              wheel_vld;

  assign pwm_line = {rght_pwm2, rght_pwm1, lft_pwm2, lft_pwm1};

  ////////////////////
  // captures
  ////////////////////
  for (genvar g = 0; g < NUM_CH; g++) begin : g_cap
    pwm_capture u_cap (
      .clk        (clk),
      .rst_n      (rst_n),
      .pwm        (pwm_line[g]),
      .sample_gnt (sample_gnt[g]),
      .sample_req (sample_req[g]),
      .duty       (duty[g])
    );
  end

  sample_arbiter u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .sample_req (sample_req),
    .duty_in    (duty),
    .sample_gnt (sample_gnt),
    .smp_vld    (smp_vld),
    .smp_ch     (smp_ch),
    .smp_duty   (smp_duty),
    .credit_ret (credit_ret)
  );

  wheel_dynamics u_wheel (
    .clk        (clk),
    .rst_n      (rst_n),
    .smp_vld    (smp_vld),
    .smp_ch     (smp_ch),
    .smp_duty   (smp_duty),
    .credit_ret (credit_ret),
    .wheel_vld  (wheel_vld),
    .omega_lft  (omega_lft),
    .omega_rght (omega_rght)
  );

  platform_integrator u_plat (
    .clk        (clk),
    .rst_n      (rst_n),
    .wheel_vld  (wheel_vld),
    .omega_lft  (omega_lft),
    .omega_rght (omega_rght),
    .phys_vld   (phys_vld),
    .heading    (heading),
    .xx         (xx),
    .yy         (yy),
    .lft_ir_n   (lft_ir_n),
    .cntr_ir_n  (cntr_ir_n),
    .rght_ir_n  (rght_ir_n)
  );

endmodule

// File: tb_knight_physics.sv
`timescale 1ns/1ns

module tb_knight_physics;
  import knight_pkg::*;

  localparam int PERIOD     = 1 << DUTY_W;  // cycles per pwm period
  localparam int EQ_STEPS   = 12;           // random equal duties, two updates each
  localparam int NORTH_MAX  = 1900;         // updates allowed to reach the border
  localparam int DECAY_UPD  = 40;
  localparam int TURN_UPD   = 120;
  localparam int MAX_CYCLES = (2 * EQ_STEPS + NORTH_MAX + DECAY_UPD + TURN_UPD + 16) * PERIOD;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              rst_d;        // rst_n one cycle late, marks the first active edge
  logic [NUM_CH-1:0] pwm;          // by channel id
  logic              check_now;
  logic              phys_vld, lft_ir_n, cntr_ir_n, rght_ir_n;
  omega_t            omega_lft, omega_rght;
  heading_t          heading;
  pos_t              xx, yy;

  duty_t duty_next [NUM_CH];       // takes effect at the next period start
  duty_t duty_cur  [NUM_CH];
  duty_t cap_duty  [NUM_CH];       // duties of the period waiting for its update
  duty_t tb_phase;                 // mirrors the capture period counters
  int    pend_cnt = 0;
  int    cycles   = 0;
  bit    failed   = 1'b0;

  // reference state
  omega_t   ref_om_l = '0;
  omega_t   ref_om_r = '0;
  heading_t ref_hd   = START_HEADING;
  pos_t     ref_xx   = START_XY;
  pos_t     ref_yy   = START_XY;
  logic     ref_lft  = 1'b1;
  logic     ref_cntr = 1'b1;
  logic     ref_rght = 1'b1;

  knight_physics_top UUT (
    .clk (clk), .rst_n (rst_n),
    .lft_pwm1 (pwm[CH_LFT_FWD]), .lft_pwm2 (pwm[CH_LFT_REV]),
    .rght_pwm1 (pwm[CH_RGHT_FWD]), .rght_pwm2 (pwm[CH_RGHT_REV]),
    .phys_vld (phys_vld), .omega_lft (omega_lft), .omega_rght (omega_rght),
    .heading (heading), .xx (xx), .yy (yy),
    .lft_ir_n (lft_ir_n), .cntr_ir_n (cntr_ir_n), .rght_ir_n (rght_ir_n)
  );

  always #2 clk = ~clk;

  ////////////////////
  // reference model
  ////////////////////
  function automatic omega_t next_omega(omega_t om, duty_t fwd, duty_t rev);
    int acc;
    int nxt;
    acc = int'(fwd) - int'(rev) - (int'(om) >>> 4) - (int'(om) >>> 6);
    acc = (acc > 4095) ? 4095 : (acc < -4096) ? -4096 : acc;  // 13 bit signed range
    if (acc > 32 || acc < -32) begin
      nxt = int'(om) + (acc >>> 3);
      nxt = (nxt > 32700) ? 32700 : (nxt < -32700) ? -32700 : nxt;
    end else begin
      nxt = int'(om) - (int'(om) >>> 6);  // friction
    end
    return omega_t'(nxt);
  endfunction

  function automatic bit in_line_band(pos_t p);
    return (p[11:0] > 12'h3E0 && p[11:0] < 12'h460) || (p[11:0] > 12'hBA0 && p[11:0] < 12'hC20);
  endfunction

  task automatic ref_update();
    int          rate, sum, st, lat, dir;
    logic [11:0] hb;
    bit          lo, hi, flip;
    ref_om_l = next_omega(ref_om_l, cap_duty[CH_LFT_FWD], cap_duty[CH_LFT_REV]);
    ref_om_r = next_omega(ref_om_r, cap_duty[CH_RGHT_FWD], cap_duty[CH_RGHT_REV]);
    rate   = (int'(ref_om_r) >>> 1) - (int'(ref_om_l) >>> 1);
    ref_hd = heading_t'(int'(ref_hd) + (rate >>> 7) + (rate >>> 8)
                        - (rate >>> 12) - (rate >>> 13) - (rate >>> 14));
    hb  = ref_hd[19:8];
    sum = int'(ref_om_l) + int'(ref_om_r);
    st  = (sum >>> 13) & 15;           // 1/8192 of the speed sum
    if (hb >= 12'hFB8 || hb <= 12'h048) dir = 0;  // north
    else if (hb >= 12'hBB8 && hb <= 12'hC48) dir = 1;
    else if (hb >= 12'h7B8 && hb <= 12'h848) dir = 2;
    else if (hb >= 12'h3B8 && hb <= 12'h448) dir = 3;
    else dir = 4;                      // between bands
    ref_lft  = 1'b1;
    ref_rght = 1'b1;
    if (ref_om_l > 16'sd1000 && ref_om_r > 16'sd1000 && dir != 4) begin
      lat  = dir[0] ? int'(ref_yy[11:0]) : int'(ref_xx[11:0]);  // across the travel axis
      lo   = sum > 22000 && lat < 'h710;
      hi   = sum > 22000 && lat > 'h8F0;
      flip = (dir == 1 || dir == 2);   // east and south see the bands mirrored
      ref_lft  = !(flip ? hi : lo);
      ref_rght = !(flip ? lo : hi);
      case (dir)
        0: ref_yy = ref_yy + pos_t'(st);
        1: ref_xx = ref_xx + pos_t'(st);
        2: ref_yy = ref_yy - pos_t'(st);
        default: ref_xx = ref_xx - pos_t'(st);
      endcase
    end
    ref_cntr = !(in_line_band(ref_xx) || in_line_band(ref_yy));
    if (ref_yy > 15'h5000) begin       // off the board edge
      ref_lft  = 1'b0;
      ref_cntr = 1'b0;
      ref_rght = 1'b0;
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) tb_phase <= '0;
    else        tb_phase <= tb_phase + 1'b1;
  end

  always @(negedge clk) begin
    if (tb_phase == '0) duty_cur = duty_next;  // new duty only on a period start
    for (int c = 0; c < NUM_CH; c++) pwm[c] = (tb_phase < duty_cur[c]);  // high first
    if (phys_vld) begin
      ref_update();
      pend_cnt = pend_cnt - 1;
    end
  end

  always @(posedge clk) begin
    rst_d <= rst_n;
    if (rst_n && tb_phase == '1) begin  // period end, duties measured this period
      cap_duty = duty_cur;
      pend_cnt = pend_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Error: run timed out after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic set_duty(duty_t lf, duty_t lr, duty_t rf, duty_t rr);
    duty_next[CH_LFT_FWD]  = lf;
    duty_next[CH_LFT_REV]  = lr;
    duty_next[CH_RGHT_FWD] = rf;
    duty_next[CH_RGHT_REV] = rr;
  endtask

  task automatic wait_updates(int n);
    repeat (n) @(posedge phys_vld);
    @(negedge clk);                    // outputs settled
  endtask

  ////////////////////
  // checks
  ////////////////////
  task automatic val_error(string name, logic [19:0] got, logic [19:0] want);
    failed = 1'b1;
    $display("** Error: %s = %h, expected %h", name, got, want);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic plain_error(string what);
    failed = 1'b1;
    $display("Error at %0t ns: %s", $time, what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  assign check_now = phys_vld || (rst_n && !rst_d);  // each update plus right after reset

  om_l_chk : assert property (@(posedge clk) disable iff (!rst_n)
    check_now |-> omega_lft == ref_om_l)
    else val_error("omega_lft", 20'(omega_lft), 20'(ref_om_l));
  om_r_chk : assert property (@(posedge clk) disable iff (!rst_n)
    check_now |-> omega_rght == ref_om_r)
    else val_error("omega_rght", 20'(omega_rght), 20'(ref_om_r));
  hd_chk : assert property (@(posedge clk) disable iff (!rst_n)
    check_now |-> heading == ref_hd)
    else val_error("heading", heading, ref_hd);
  xx_chk : assert property (@(posedge clk) disable iff (!rst_n)
    check_now |-> xx == ref_xx)
    else val_error("xx", 20'(xx), 20'(ref_xx));
  yy_chk : assert property (@(posedge clk) disable iff (!rst_n)
    check_now |-> yy == ref_yy)
    else val_error("yy", 20'(yy), 20'(ref_yy));
  lft_chk : assert property (@(posedge clk) disable iff (!rst_n)
    check_now |-> lft_ir_n == ref_lft)
    else val_error("lft_ir_n", 20'(lft_ir_n), 20'(ref_lft));
  cntr_chk : assert property (@(posedge clk) disable iff (!rst_n)
    check_now |-> cntr_ir_n == ref_cntr)
    else val_error("cntr_ir_n", 20'(cntr_ir_n), 20'(ref_cntr));
  rght_chk : assert property (@(posedge clk) disable iff (!rst_n)
    check_now |-> rght_ir_n == ref_rght)
    else val_error("rght_ir_n", 20'(rght_ir_n), 20'(ref_rght));

  pulse_chk : assert property (@(posedge clk) disable iff (!rst_n) phys_vld |=> !phys_vld)
    else plain_error("phys_vld stayed high for more than one cycle");
  period_chk : assert property (@(posedge clk) disable iff (!rst_n)
    (tb_phase == '1) |-> pend_cnt == 0) else plain_error("no update between two period ends");
  // the update was already counted off on the falling edge inside the pulse
  spurious_chk : assert property (@(posedge clk) disable iff (!rst_n)
    phys_vld |-> pend_cnt == 0) else plain_error("update without a finished period");
  // slow left wheel, board position must hold
  hold_chk : assert property (@(posedge clk) disable iff (!rst_n)
    (phys_vld && omega_lft <= MOVE_MIN) |-> $stable(xx) && $stable(yy))
    else plain_error("position moved with the left wheel below travel speed");

  initial begin
    duty_t d;
    void'($urandom(76));
    rst_n = 1'b0;
    pwm   = '0;
    set_duty('0, '0, '0, '0);
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (EQ_STEPS) begin            // equal forward drive, heading stays put
      d = duty_t'($urandom_range(2047, 200));
      set_duty(d, '0, d, '0);
      wait_updates(2);
    end
    set_duty('1, '0, '1, '0);          // full ahead, north across the line bands
    while (yy <= BORDER_Y) wait_updates(1);
    wait_updates(4);
    set_duty('0, '0, '0, '0);          // coast down
    wait_updates(DECAY_UPD);
    d = duty_t'($urandom_range(2047, 1024));
    set_duty('0, '1, d, '0);           // brake left, turn on the right wheel
    wait_updates(TURN_UPD);
    if (!failed) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("CHECKS FAILED");
      $fatal(1, "run ended with errors");
    end
  end

endmodule

// File: sources.f
knight_pkg.sv
pwm_capture.sv
sample_arbiter.sv
wheel_dynamics.sv
platform_integrator.sv
knight_physics_top.sv
tb_knight_physics.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the knight physics testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_knight_physics -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi
exit 0
